//--- Bender.yml
package:
  name: phaethon_core

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/phaethonIsaPkg.sv
      - rtl/phaethonCoreTypesPkg.sv
      - rtl/regPortIf.sv
      - rtl/instrDecoder.sv
      - rtl/regFile.sv
      - rtl/execUnit.sv
      - rtl/coreSequencer.sv
      - rtl/phaethonCore.sv
  - target: simulation
    files:
      - verif/phaethonCore_props.sv
      - verif/phaethonCoreTb.sv

//--- flist.f
+incdir+rtl
rtl/phaethonIsaPkg.sv
rtl/phaethonCoreTypesPkg.sv
rtl/regPortIf.sv
rtl/instrDecoder.sv
rtl/regFile.sv
rtl/execUnit.sv
rtl/coreSequencer.sv
rtl/phaethonCore.sv
verif/phaethonCore_props.sv
verif/phaethonCoreTb.sv

//--- rtl/coreSequencer.sv
`timescale 1ns/1ps
`include "phaethon_settings.svh"

module coreSequencer (
  input  logic                           clk,
  input  logic                           reset,
  input  phaethonCoreTypesPkg::word_t    ramIn,
  input  phaethonIsaPkg::instrFields_t   fields,
  input  logic                           isLong,
  input  logic                           isMem,
  input  phaethonCoreTypesPkg::word_t    nextPointer,
  input  phaethonCoreTypesPkg::word_t    codeBase,
  input  phaethonCoreTypesPkg::word_t    stackPointer,
  output phaethonCoreTypesPkg::word_t    ramAddress,
  output phaethonCoreTypesPkg::word_t    ramOut,
  output logic                           readReq,
  output logic                           writeReq,
  output phaethonCoreTypesPkg::seqStep_t step,
  output phaethonCoreTypesPkg::word_t    instrPointer,
  output phaethonCoreTypesPkg::word_t    constWord,
  output phaethonCoreTypesPkg::word_t    loadWord,
  regPortIf.sequencer                    regs
);

  phaethonCoreTypesPkg::seqStep_t stepNext;
  phaethonCoreTypesPkg::word_t    addrNext;
  phaethonCoreTypesPkg::word_t    dataNext;
  logic                           readNext;
  logic                           writeNext;
  logic                           memWrite;

  // je and jne need the flags in r1 instead of field A
  assign regs.rdIdxA = (fields.opcode inside {phaethonIsaPkg::opJeC, phaethonIsaPkg::opJneC}) ?
                       phaethonCoreTypesPkg::regIdx_t'(1) :
                       phaethonCoreTypesPkg::regIdx_t'(fields.regA);
  assign regs.rdIdxB = phaethonCoreTypesPkg::regIdx_t'(fields.regB);
  assign regs.rdIdxC = phaethonCoreTypesPkg::regIdx_t'(fields.regC);

  assign memWrite = fields.opcode inside {phaethonIsaPkg::opMovdCR, phaethonIsaPkg::opMovdRoR,
                                          phaethonIsaPkg::opPushR, phaethonIsaPkg::opCallR};

  always_comb begin
    stepNext  = step;
    readNext  = 1'b0;          // Strobes last one cycle
    writeNext = 1'b0;
    addrNext  = ramAddress;
    dataNext  = ramOut;
    case (step)
      phaethonCoreTypesPkg::stepFetchReq: begin
        readNext = 1'b1;
        addrNext = codeBase + instrPointer;
        stepNext = phaethonCoreTypesPkg::stepFetchWait;
      end
      phaethonCoreTypesPkg::stepFetchWait: stepNext = phaethonCoreTypesPkg::stepDecode;
      phaethonCoreTypesPkg::stepDecode:    stepNext = phaethonCoreTypesPkg::stepRegRead;
      phaethonCoreTypesPkg::stepRegRead: begin
        if (isLong) begin
          // Constant word sits right after the opcode word
          readNext = 1'b1;
          addrNext = codeBase + instrPointer + `PH_SHORT_INSTR_BYTES;
          stepNext = phaethonCoreTypesPkg::stepConstWait;
        end else if (isMem) begin
          stepNext = phaethonCoreTypesPkg::stepMemReq;
        end else begin
          stepNext = phaethonCoreTypesPkg::stepExecute;
        end
      end
      phaethonCoreTypesPkg::stepConstWait: stepNext = phaethonCoreTypesPkg::stepConstComplete;
      phaethonCoreTypesPkg::stepConstComplete: begin
        stepNext = isMem ? phaethonCoreTypesPkg::stepMemReq : phaethonCoreTypesPkg::stepExecute;
      end
      phaethonCoreTypesPkg::stepMemReq: begin
        readNext  = !memWrite;
        writeNext = memWrite;
        case (fields.opcode)
          phaethonIsaPkg::opMovRdC,
          phaethonIsaPkg::opMovdCR:  addrNext = constWord;                 // Absolute
          phaethonIsaPkg::opMovRdR:  addrNext = regs.rdDataB;
          phaethonIsaPkg::opMovRdRo: addrNext = regs.rdDataB + constWord;
          phaethonIsaPkg::opMovdRoR: addrNext = regs.rdDataA + constWord;
          phaethonIsaPkg::opPushR,
          phaethonIsaPkg::opCallR:   addrNext = stackPointer;              // Next free slot
          default:                   addrNext = stackPointer - `PH_STACK_STEP;  // Pop, ret
        endcase
        case (fields.opcode)
          phaethonIsaPkg::opPushR: dataNext = regs.rdDataA;
          phaethonIsaPkg::opCallR: dataNext = instrPointer;   // Own address, ret adds 4
          default:                 dataNext = regs.rdDataB;
        endcase
        stepNext = phaethonCoreTypesPkg::stepMemWait;
      end
      phaethonCoreTypesPkg::stepMemWait:     stepNext = phaethonCoreTypesPkg::stepMemComplete;
      phaethonCoreTypesPkg::stepMemComplete: stepNext = phaethonCoreTypesPkg::stepExecute;
      default:                               stepNext = phaethonCoreTypesPkg::stepFetchReq;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      step         <= phaethonCoreTypesPkg::stepFetchReq;
      readReq      <= 1'b0;
      writeReq     <= 1'b0;
      instrPointer <= '0;
    end else begin
      step     <= stepNext;
      readReq  <= readNext;
      writeReq <= writeNext;
      if (step == phaethonCoreTypesPkg::stepExecute) instrPointer <= nextPointer;
    end
  end

  // RAM word valid two edges after the strobe is sampled
  always_ff @(posedge clk) begin
    ramAddress <= addrNext;
    ramOut     <= dataNext;
    if (step == phaethonCoreTypesPkg::stepConstComplete) constWord <= ramIn;
    if (step == phaethonCoreTypesPkg::stepMemComplete) loadWord <= ramIn;
  end

endmodule

//--- rtl/execUnit.sv
`timescale 1ns/1ps
`include "phaethon_settings.svh"

module execUnit (
  input  logic                           clk,
  input  logic                           reset,
  input  phaethonCoreTypesPkg::seqStep_t step,
  input  phaethonIsaPkg::instrFields_t   fields,
  input  phaethonCoreTypesPkg::word_t    constWord,
  input  phaethonCoreTypesPkg::word_t    loadWord,
  input  phaethonCoreTypesPkg::word_t    instrPointer,
  regPortIf.exec                         regs,
  output phaethonCoreTypesPkg::word_t    nextPointer,
  output phaethonCoreTypesPkg::word_t    debugOut,
  output logic                           debugValid
);

  phaethonIsaPkg::opcode_t      op;
  phaethonCoreTypesPkg::word_t  a;
  phaethonCoreTypesPkg::word_t  b;
  phaethonCoreTypesPkg::word_t  c;
  phaethonCoreTypesPkg::word_t  cmpRhs;
  phaethonCoreTypesPkg::word_t  result;
  phaethonCoreTypesPkg::word_t  seqPointer;
  phaethonCoreTypesPkg::word_t  lastDebug;
  phaethonCoreTypesPkg::flags_t cmpFlags;
  phaethonCoreTypesPkg::flags_t heldFlags;
  logic                         writesReg;
  logic                         inExec;

  assign op     = fields.opcode;
  assign a      = regs.rdDataA;
  assign b      = regs.rdDataB;
  assign c      = regs.rdDataC;
  assign inExec = (step == phaethonCoreTypesPkg::stepExecute);

  // Unsigned compare, register or constant on the right
  assign cmpRhs           = (op == phaethonIsaPkg::opCmpRC) ? constWord : b;
  assign cmpFlags.equal   = (a == cmpRhs);
  assign cmpFlags.less    = (a < cmpRhs);
  assign cmpFlags.greater = (a > cmpRhs);
  assign heldFlags = phaethonCoreTypesPkg::flags_t'(a[2:0]);   // r1 on port A for je/jne

  always_comb begin
    result    = '0;
    writesReg = 1'b1;
    case (op)
      phaethonIsaPkg::opMovRC:    result = constWord;
      phaethonIsaPkg::opMovRR:    result = b;
      phaethonIsaPkg::opMovRdC,
      phaethonIsaPkg::opMovRdR,
      phaethonIsaPkg::opMovRdRo,
      phaethonIsaPkg::opPopR:     result = loadWord;
      phaethonIsaPkg::opAddRRC:   result = b + constWord;
      phaethonIsaPkg::opAddRRR:   result = b + c;
      phaethonIsaPkg::opSubRRC:   result = b - constWord;
      phaethonIsaPkg::opSubRRR:   result = b - c;
      phaethonIsaPkg::opIncR:     result = a + 1;
      phaethonIsaPkg::opDecR:     result = a - 1;
      phaethonIsaPkg::opShlRRR:   result = b << c;
      phaethonIsaPkg::opShrRRR:   result = b >> c;   // Logical
      phaethonIsaPkg::opNegRR:    result = -b;
      phaethonIsaPkg::opCmpRR,
      phaethonIsaPkg::opCmpRC:    result = phaethonCoreTypesPkg::word_t'(cmpFlags);
      phaethonIsaPkg::opCmpERRR:  result = phaethonCoreTypesPkg::word_t'(b == c);
      phaethonIsaPkg::opCmpNeRRR: result = phaethonCoreTypesPkg::word_t'(b != c);
      phaethonIsaPkg::opCmpLtRRR: result = phaethonCoreTypesPkg::word_t'(b < c);
      phaethonIsaPkg::opCmpGtRRR: result = phaethonCoreTypesPkg::word_t'(b > c);
      default:                    writesReg = 1'b0;  // Jumps, stores, push, debug
    endcase
  end

  // Result write, flag compares target r1
  assign regs.wrEn   = inExec && writesReg;
  assign regs.wrData = result;
  assign regs.wrIdx  = (op inside {phaethonIsaPkg::opCmpRR, phaethonIsaPkg::opCmpRC}) ?
                       phaethonCoreTypesPkg::regIdx_t'(1) :
                       phaethonCoreTypesPkg::regIdx_t'(fields.regA);

  // Stack grows upward
  assign regs.spAdjEn = inExec && (op inside {phaethonIsaPkg::opPushR, phaethonIsaPkg::opPopR,
                                              phaethonIsaPkg::opCallR, phaethonIsaPkg::opRet});
  assign regs.spDelta = (op inside {phaethonIsaPkg::opPushR, phaethonIsaPkg::opCallR}) ?
                        phaethonCoreTypesPkg::word_t'(`PH_STACK_STEP) :
                        phaethonCoreTypesPkg::word_t'(-`PH_STACK_STEP);

  assign seqPointer = instrPointer + (phaethonIsaPkg::isLongOpcode(op) ?
                      `PH_LONG_INSTR_BYTES : `PH_SHORT_INSTR_BYTES);

  always_comb begin
    case (op)
      phaethonIsaPkg::opJmpC:  nextPointer = constWord;
      phaethonIsaPkg::opJeC:   nextPointer = heldFlags.equal ? constWord : seqPointer;
      phaethonIsaPkg::opJneC:  nextPointer = heldFlags.equal ? seqPointer : constWord;
      phaethonIsaPkg::opJzRC:  nextPointer = (c == '0) ? constWord : seqPointer;
      phaethonIsaPkg::opJnzRC: nextPointer = (c != '0) ? constWord : seqPointer;
      phaethonIsaPkg::opCallR: nextPointer = a;
      phaethonIsaPkg::opRet:   nextPointer = loadWord + `PH_SHORT_INSTR_BYTES;  // Skip the call
      phaethonIsaPkg::opStall: nextPointer = instrPointer;
      default:                 nextPointer = seqPointer;
    endcase
  end

  // Live value during the pulse, held value after
  assign debugValid = inExec && (op == phaethonIsaPkg::opDoutR);
  assign debugOut   = debugValid ? a : lastDebug;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) lastDebug <= '0;
    else if (debugValid) lastDebug <= a;
  end

endmodule

//--- rtl/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
  input  logic                           clk,
  input  logic                           reset,
  input  phaethonCoreTypesPkg::word_t    ramIn,
  input  phaethonCoreTypesPkg::seqStep_t step,
  output phaethonIsaPkg::instrFields_t   fields,
  output logic                           isLong,
  output logic                           isMem
);

  phaethonIsaPkg::instrFields_t rawFields;
  logic                         rawLong;
  logic                         rawMem;

  // Split the word straight off the RAM bus
  assign rawFields = phaethonIsaPkg::instrFields_t'(ramIn);

  // Class bits evaluated once per instruction
  assign rawLong = phaethonIsaPkg::isLongOpcode(rawFields.opcode);
  assign rawMem  = phaethonIsaPkg::isMemOpcode(rawFields.opcode);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      fields <= '0;            // Opcode zero is stall
      isLong <= 1'b0;
      isMem  <= 1'b0;
    end else if (step == phaethonCoreTypesPkg::stepDecode) begin
      // Fetch data valid on this edge
      fields <= rawFields;
      isLong <= rawLong;
      isMem  <= rawMem;
    end
  end

endmodule

//--- rtl/phaethonCore.sv
`timescale 1ns/1ps

module phaethonCore (
  input  logic                        clk,
  input  logic                        reset,
  input  phaethonCoreTypesPkg::word_t ramIn,
  output phaethonCoreTypesPkg::word_t ramAddress,
  output phaethonCoreTypesPkg::word_t ramOut,
  output logic                        readReq,
  output logic                        writeReq,
  output phaethonCoreTypesPkg::word_t instrPointer,
  output phaethonCoreTypesPkg::word_t debugOut,
  output logic                        debugValid
);

  phaethonCoreTypesPkg::seqStep_t step;
  phaethonIsaPkg::instrFields_t   fields;     // Held from decode to next fetch
  logic                           isLong;
  logic                           isMem;
  phaethonCoreTypesPkg::word_t    nextPointer;
  phaethonCoreTypesPkg::word_t    codeBase;
  phaethonCoreTypesPkg::word_t    stackPointer;
  phaethonCoreTypesPkg::word_t    constWord;
  phaethonCoreTypesPkg::word_t    loadWord;

  regPortIf regs ();

  coreSequencer coreSequencer_i (
    .clk, .reset, .ramIn, .fields, .isLong, .isMem, .nextPointer, .codeBase, .stackPointer,
    .ramAddress, .ramOut, .readReq, .writeReq, .step, .instrPointer, .constWord, .loadWord,
    .regs(regs.sequencer)
  );

  instrDecoder instrDecoder_i (
    .clk, .reset, .ramIn, .step, .fields, .isLong, .isMem
  );

  regFile regFile_i (
    .clk, .reset, .regs(regs.target), .codeBase, .stackPointer
  );

  execUnit execUnit_i (
    .clk, .reset, .step, .fields, .constWord, .loadWord, .instrPointer,
    .regs(regs.exec), .nextPointer, .debugOut, .debugValid
  );

endmodule

//--- rtl/phaethonCoreTypesPkg.sv
`include "phaethon_settings.svh"

package phaethonCoreTypesPkg;

  typedef logic [`PH_WORD_WIDTH-1:0]        word_t;
  typedef logic [$clog2(`PH_REG_COUNT)-1:0] regIdx_t;

  // One state per sequencer cycle
  typedef enum logic [3:0] {
    stepFetchReq,
    stepFetchWait,
    stepDecode,
    stepRegRead,
    stepConstWait,
    stepConstComplete,
    stepMemReq,
    stepMemWait,
    stepMemComplete,
    stepExecute
  } seqStep_t;

  // Low bits of r1, equal in bit 0
  typedef struct packed {
    logic greater;
    logic less;
    logic equal;
  } flags_t;

endpackage

//--- rtl/phaethonIsaPkg.sv
package phaethonIsaPkg;

  // Opcode byte values
  typedef enum logic [7:0] {
    opStall    = 8'h00,  // Spin on same pointer
    opMovRR    = 8'h01,
    opMovRC    = 8'h02,
    opMovRdC   = 8'h03,  // Load absolute
    opMovRdR   = 8'h04,  // Load register-indirect
    opMovRdRo  = 8'h05,  // Load register plus offset
    opMovdCR   = 8'h06,  // Store absolute
    opMovdRoR  = 8'h07,  // Store register plus offset
    opPushR    = 8'h08,
    opPopR     = 8'h09,
    opCallR    = 8'h0a,
    opRet      = 8'h0b,
    opAddRRC   = 8'h10,
    opAddRRR   = 8'h11,
    opSubRRC   = 8'h12,
    opSubRRR   = 8'h13,
    opIncR     = 8'h14,
    opDecR     = 8'h15,
    opShlRRR   = 8'h16,
    opShrRRR   = 8'h17,
    opNegRR    = 8'h18,
    opCmpRR    = 8'h20,  // Compare into flags
    opCmpRC    = 8'h21,
    opCmpERRR  = 8'h22,  // Three-register compares
    opCmpNeRRR = 8'h23,
    opCmpLtRRR = 8'h24,
    opCmpGtRRR = 8'h25,
    opJmpC     = 8'h30,
    opJeC      = 8'h31,
    opJneC     = 8'h32,
    opJzRC     = 8'h33,  // Tests third register
    opJnzRC    = 8'h34,
    opDoutR    = 8'h40   // Debug output
  } opcode_t;

  // First instruction word, opcode in the low byte
  typedef struct packed {
    logic [7:0] regC;
    logic [7:0] regB;
    logic [7:0] regA;
    opcode_t    opcode;
  } instrFields_t;

  // Followed by a constant word
  function automatic logic isLongOpcode(opcode_t op);
    return op inside {opMovRC, opMovRdC, opMovRdRo, opMovdCR, opMovdRoR, opAddRRC,
                      opSubRRC, opCmpRC, opJmpC, opJeC, opJneC, opJzRC, opJnzRC};
  endfunction

  // Needs a data RAM access
  function automatic logic isMemOpcode(opcode_t op);
    return op inside {opMovRdC, opMovRdR, opMovRdRo, opMovdCR, opMovdRoR,
                      opPushR, opPopR, opCallR, opRet};
  endfunction

endpackage

//--- rtl/phaethon_settings.svh
`ifndef PHAETHON_SETTINGS_SVH
`define PHAETHON_SETTINGS_SVH

// Datapath and address width
`define PH_WORD_WIDTH 32

// Register file depth, r0 stack, r1 flags, r2 code base
`define PH_REG_COUNT 16

// Bytes per stack slot
`define PH_STACK_STEP 4

// Instruction sizes in bytes
`define PH_SHORT_INSTR_BYTES 4
`define PH_LONG_INSTR_BYTES 8   // Opcode word plus constant word

`endif

//--- rtl/regFile.sv
`timescale 1ns/1ps
`include "phaethon_settings.svh"

module regFile (
  input  logic                        clk,
  input  logic                        reset,
  regPortIf.target                    regs,
  output phaethonCoreTypesPkg::word_t codeBase,
  output phaethonCoreTypesPkg::word_t stackPointer
);

  phaethonCoreTypesPkg::word_t regArray [`PH_REG_COUNT];

  // Three combinational read ports
  assign regs.rdDataA = regArray[regs.rdIdxA];
  assign regs.rdDataB = regArray[regs.rdIdxB];
  assign regs.rdDataC = regArray[regs.rdIdxC];

  assign stackPointer = regArray[0];
  assign codeBase     = regArray[2];   // Added to every fetch

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < `PH_REG_COUNT; i++) begin
        regArray[i] <= '0;
      end
    end else begin
      if (regs.wrEn) regArray[regs.wrIdx] <= regs.wrData;
      // Later assignment, so the adjust wins on r0
      if (regs.spAdjEn) regArray[0] <= regArray[0] + regs.spDelta;
    end
  end

endmodule

//--- rtl/regPortIf.sv
`timescale 1ns/1ps

interface regPortIf;
  phaethonCoreTypesPkg::regIdx_t rdIdxA;
  phaethonCoreTypesPkg::regIdx_t rdIdxB;
  phaethonCoreTypesPkg::regIdx_t rdIdxC;
  phaethonCoreTypesPkg::word_t   rdDataA;   // Combinational read data
  phaethonCoreTypesPkg::word_t   rdDataB;
  phaethonCoreTypesPkg::word_t   rdDataC;
  logic                          wrEn;      // Result write, execute step only
  phaethonCoreTypesPkg::regIdx_t wrIdx;
  phaethonCoreTypesPkg::word_t   wrData;
  logic                          spAdjEn;   // Stack pointer adjust
  phaethonCoreTypesPkg::word_t   spDelta;   // Plus or minus one slot

  modport sequencer (output rdIdxA, rdIdxB, rdIdxC, input rdDataA, rdDataB);

  modport exec (input rdDataA, rdDataB, rdDataC,
                output wrEn, wrIdx, wrData, spAdjEn, spDelta);

  modport target (input rdIdxA, rdIdxB, rdIdxC, wrEn, wrIdx, wrData, spAdjEn, spDelta,
                  output rdDataA, rdDataB, rdDataC);
endinterface

//--- verif/phaethonCoreTb.sv
`timescale 1ns/1ps
`include "phaethon_settings.svh"

module phaethonCoreTb;

  localparam int cycleLimit = 2000;   // Six short programs plus resets, with margin
  localparam int ramDepth   = 1024;   // 4 KB of word RAM
  localparam phaethonCoreTypesPkg::word_t takenMark = 32'h0000_007a;
  localparam phaethonCoreTypesPkg::word_t fallMark  = 32'h0000_00fa;

  logic                        clk;
  logic                        reset;
  phaethonCoreTypesPkg::word_t ramIn;
  phaethonCoreTypesPkg::word_t ramAddress;
  phaethonCoreTypesPkg::word_t ramOut;
  logic                        readReq;
  logic                        writeReq;
  phaethonCoreTypesPkg::word_t instrPointer;
  phaethonCoreTypesPkg::word_t debugOut;
  logic                        debugValid;

  phaethonCoreTypesPkg::word_t ramWords [ramDepth];
  phaethonCoreTypesPkg::word_t debugSeen [$];   // Values seen on debugValid
  phaethonCoreTypesPkg::word_t debugWant [$];
  phaethonCoreTypesPkg::word_t pc;              // Next free program address
  phaethonCoreTypesPkg::word_t stallAddr;
  phaethonCoreTypesPkg::word_t sampledAddr = '0;
  phaethonCoreTypesPkg::word_t sampledData = '0;
  logic  sampledRead  = 1'b0;
  logic  sampledWrite = 1'b0;
  int    errorCount = 0;
  int    checkCount = 0;
  int    cycleCount = 0;
  int    assertFails = 0;
  string testName;

  phaethonCore phaethonCore_i (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk)
    cycleCount <= cycleCount + 1;

  initial begin
    wait (cycleCount >= cycleLimit);
    $display("Timeout: no verdict after %0d cycles", cycleLimit);
    $display("Regression failed");
    $finish;
  end

  // Strobes and debug pulses sampled mid-cycle
  always @(negedge clk) begin
    sampledRead  = readReq;
    sampledWrite = writeReq;
    sampledAddr  = ramAddress;
    sampledData  = ramOut;
    if (debugValid) debugSeen.push_back(debugOut);
  end

  // Store on the sampling edge, read data valid one edge later
  always @(posedge clk) begin
    #1;
    if (sampledWrite) ramWords[sampledAddr[11:2]] = sampledData;
    if (sampledRead) ramIn = ramWords[sampledAddr[11:2]];
  end

  task automatic checkWord(input string name, input phaethonCoreTypesPkg::word_t expected,
                           input phaethonCoreTypesPkg::word_t actual);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("MISMATCH %s %s: expected %h, actual %h", testName, name, expected, actual);
    end
  endtask

  task automatic checkDebug(input string name, input phaethonCoreTypesPkg::word_t expected,
                            input phaethonCoreTypesPkg::word_t actual);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("MISMATCH %s %s: expected %h, actual %h", testName, name, expected, actual);
    end
  endtask

  // Opcode in the low byte, then registers A, B, C
  task automatic emit(input phaethonIsaPkg::opcode_t op, input int a, input int b, input int c);
    ramWords[pc >> 2] = {c[7:0], b[7:0], a[7:0], op};
    pc += `PH_SHORT_INSTR_BYTES;
  endtask

  task automatic emitLong(input phaethonIsaPkg::opcode_t op, input int a, input int b,
                          input int c, input phaethonCoreTypesPkg::word_t k);
    emit(op, a, b, c);
    ramWords[pc >> 2] = k;   // Constant word follows
    pc += `PH_LONG_INSTR_BYTES - `PH_SHORT_INSTR_BYTES;
  endtask

  task automatic showReg(input int r, input phaethonCoreTypesPkg::word_t want);
    emit(phaethonIsaPkg::opDoutR, r, 0, 0);
    debugWant.push_back(want);
  endtask

  task automatic emitStall();
    stallAddr = pc;
    emit(phaethonIsaPkg::opStall, 0, 0, 0);
  endtask

  function automatic phaethonCoreTypesPkg::word_t flagsWord(
      input phaethonCoreTypesPkg::word_t lhs, input phaethonCoreTypesPkg::word_t rhs);
    phaethonCoreTypesPkg::flags_t f;
    f.equal   = (lhs == rhs);   // Unsigned compare
    f.less    = (lhs < rhs);
    f.greater = (lhs > rhs);
    return phaethonCoreTypesPkg::word_t'(f);
  endfunction

  task automatic startTest(input string name);
    testName = name;
    @(posedge clk);
    #1 reset = 1'b1;
    @(negedge clk);   // RAM model idle from here on
    for (int i = 0; i < ramDepth; i++)
      ramWords[i] = 32'hbad0_0000 | (i << 2);
    pc = '0;
    debugSeen.delete();
    debugWant.delete();
  endtask

  task automatic releaseReset();
    repeat (10) @(posedge clk);
    #1 reset = 1'b0;
  endtask

  task automatic awaitStall();
    while (instrPointer !== stallAddr)
      @(negedge clk);
    if (debugSeen.size() != debugWant.size()) begin
      errorCount++;
      $display("%s: expected %0d debug pulses but saw %0d", testName, debugWant.size(),
               debugSeen.size());
    end
    foreach (debugWant[i]) begin
      if (i < debugSeen.size()) checkDebug($sformatf("debug %0d", i), debugWant[i], debugSeen[i]);
    end
    // Last debug value stays on the port between pulses
    if (debugWant.size() > 0)
      checkDebug("held debug value", debugWant[$], debugOut);
  endtask

  task automatic runProgram();
    releaseReset();
    awaitStall();
  endtask

  task automatic arithmeticTest();
    phaethonCoreTypesPkg::word_t x;
    phaethonCoreTypesPkg::word_t y;
    phaethonCoreTypesPkg::word_t xi;
    phaethonCoreTypesPkg::word_t yd;
    x  = 32'h7fff_fff0;
    y  = 32'h0000_0025;
    xi = x + 1;
    yd = y - 1;
    startTest("arithmetic");
    emitLong(phaethonIsaPkg::opMovRC, 3, 0, 0, x);
    emitLong(phaethonIsaPkg::opMovRC, 4, 0, 0, y);
    emitLong(phaethonIsaPkg::opMovRC, 5, 0, 0, 32'd5);   // Shift amount
    emit(phaethonIsaPkg::opAddRRR, 6, 3, 4);
    showReg(6, x + y);
    emit(phaethonIsaPkg::opSubRRR, 7, 4, 3);
    showReg(7, y - x);                                  // Wraps below zero
    emitLong(phaethonIsaPkg::opAddRRC, 8, 3, 0, 32'h8000_0020);
    showReg(8, x + 32'h8000_0020);                      // Wraps past 2^32
    emitLong(phaethonIsaPkg::opSubRRC, 9, 4, 0, 32'h30);
    showReg(9, y - 32'h30);
    emit(phaethonIsaPkg::opIncR, 3, 0, 0);
    showReg(3, xi);
    emit(phaethonIsaPkg::opDecR, 4, 0, 0);
    showReg(4, yd);
    emit(phaethonIsaPkg::opShlRRR, 10, 3, 5);
    showReg(10, xi << 5);
    emit(phaethonIsaPkg::opShrRRR, 11, 3, 5);
    showReg(11, xi >> 5);
    emit(phaethonIsaPkg::opNegRR, 12, 4, 0);
    showReg(12, -yd);
    emitStall();
    runProgram();
  endtask

  task automatic loadStoreTest();
    phaethonCoreTypesPkg::word_t p;
    phaethonCoreTypesPkg::word_t q;
    p = 32'hcafe_f00d;
    q = 32'h1234_5678;
    startTest("load and store");
    emitLong(phaethonIsaPkg::opMovRC, 3, 0, 0, p);
    emitLong(phaethonIsaPkg::opMovRC, 4, 0, 0, q);
    emitLong(phaethonIsaPkg::opMovRC, 5, 0, 0, 32'h200);     // Base register
    emitLong(phaethonIsaPkg::opMovdCR, 0, 3, 0, 32'h100);    // Absolute store of r3
    emitLong(phaethonIsaPkg::opMovdRoR, 5, 4, 0, 32'h8);     // r4 to r5 plus 8
    emitLong(phaethonIsaPkg::opMovRdC, 6, 0, 0, 32'h100);
    showReg(6, p);
    emitLong(phaethonIsaPkg::opMovRC, 7, 0, 0, 32'h208);
    emit(phaethonIsaPkg::opMovRdR, 8, 7, 0);
    showReg(8, q);
    emitLong(phaethonIsaPkg::opMovRdRo, 9, 5, 0, 32'h8);
    showReg(9, q);
    emitStall();
    runProgram();
    checkWord("word at 0x100", p, ramWords[32'h100 >> 2]);
    checkWord("word at 0x208", q, ramWords[32'h208 >> 2]);
  endtask

  task automatic stackTest();
    phaethonCoreTypesPkg::word_t p;
    phaethonCoreTypesPkg::word_t q;
    p = 32'haaaa_0001;
    q = 32'hbbbb_0002;
    startTest("stack");
    emitLong(phaethonIsaPkg::opMovRC, 0, 0, 0, 32'h300);     // Stack pointer
    emitLong(phaethonIsaPkg::opMovRC, 3, 0, 0, p);
    emitLong(phaethonIsaPkg::opMovRC, 4, 0, 0, q);
    emit(phaethonIsaPkg::opPushR, 3, 0, 0);
    emit(phaethonIsaPkg::opPushR, 4, 0, 0);
    emit(phaethonIsaPkg::opPopR, 5, 0, 0);
    emit(phaethonIsaPkg::opPopR, 6, 0, 0);
    showReg(5, q);                                          // Last in, first out
    showReg(6, p);
    showReg(0, 32'h300);
    emitStall();
    runProgram();
    checkWord("first slot", p, ramWords[32'h300 >> 2]);
    checkWord("second slot", q, ramWords[(32'h300 + `PH_STACK_STEP) >> 2]);
  endtask

  task automatic callTest();
    phaethonCoreTypesPkg::word_t targetSlot;
    phaethonCoreTypesPkg::word_t callAddr;
    startTest("call and return");
    emitLong(phaethonIsaPkg::opMovRC, 0, 0, 0, 32'h380);
    emitLong(phaethonIsaPkg::opMovRC, 3, 0, 0, 32'h0);
    targetSlot = pc - 4;                                    // Routine address patched below
    emitLong(phaethonIsaPkg::opMovRC, 4, 0, 0, 32'h0000_af7e);
    callAddr = pc;
    emit(phaethonIsaPkg::opCallR, 3, 0, 0);
    emit(phaethonIsaPkg::opDoutR, 4, 0, 0);
    emitStall();
    ramWords[targetSlot >> 2] = pc;
    emitLong(phaethonIsaPkg::opMovRC, 5, 0, 0, 32'h0000_3a5c);
    emit(phaethonIsaPkg::opDoutR, 5, 0, 0);
    emit(phaethonIsaPkg::opRet, 0, 0, 0);
    debugWant.push_back(32'h0000_3a5c);                     // Marker before return path
    debugWant.push_back(32'h0000_af7e);
    runProgram();
    checkWord("saved return word", callAddr, ramWords[32'h380 >> 2]);
  endtask

  // Branch, fall-through marker, then target marker
  task automatic branchBlock(input phaethonIsaPkg::opcode_t op, input int testReg,
                             input bit taken);
    emitLong(op, 0, 0, testReg, pc + `PH_LONG_INSTR_BYTES + `PH_SHORT_INSTR_BYTES);
    emit(phaethonIsaPkg::opDoutR, 11, 0, 0);
    emit(phaethonIsaPkg::opDoutR, 10, 0, 0);
    if (!taken) debugWant.push_back(fallMark);
    debugWant.push_back(takenMark);
  endtask

  task automatic branchTest();
    phaethonCoreTypesPkg::word_t a;
    phaethonCoreTypesPkg::word_t b;
    phaethonCoreTypesPkg::word_t k;
    a = 32'd7;
    b = 32'd7;
    k = 32'd9;
    startTest("compare and branch");
    emitLong(phaethonIsaPkg::opMovRC, 3, 0, 0, a);
    emitLong(phaethonIsaPkg::opMovRC, 4, 0, 0, b);
    emitLong(phaethonIsaPkg::opMovRC, 5, 0, 0, 32'd0);
    emitLong(phaethonIsaPkg::opMovRC, 10, 0, 0, takenMark);
    emitLong(phaethonIsaPkg::opMovRC, 11, 0, 0, fallMark);
    emit(phaethonIsaPkg::opCmpRR, 3, 4, 0);
    showReg(1, flagsWord(a, b));
    branchBlock(phaethonIsaPkg::opJeC, 0, a == b);
    branchBlock(phaethonIsaPkg::opJneC, 0, a != b);
    emitLong(phaethonIsaPkg::opCmpRC, 3, 0, 0, k);
    showReg(1, flagsWord(a, k));
    branchBlock(phaethonIsaPkg::opJeC, 0, a == k);
    branchBlock(phaethonIsaPkg::opJneC, 0, a != k);
    branchBlock(phaethonIsaPkg::opJzRC, 5, 1'b1);        // r5 holds zero
    branchBlock(phaethonIsaPkg::opJnzRC, 5, 1'b0);
    branchBlock(phaethonIsaPkg::opJzRC, 3, a == 0);
    branchBlock(phaethonIsaPkg::opJnzRC, 3, a != 0);
    emitStall();
    runProgram();
  endtask

  task automatic timingTest();
    phaethonCoreTypesPkg::word_t secondAddr;
    int n;
    int firstAt;
    int secondAt;
    startTest("timing and reset");
    emit(phaethonIsaPkg::opIncR, 3, 0, 0);
    emit(phaethonIsaPkg::opIncR, 3, 0, 0);
    showReg(3, 32'd2);
    emitStall();
    checkWord("pointer in reset", 32'h0, instrPointer);
    releaseReset();
    n        = 0;
    firstAt  = 0;
    secondAt = 0;
    while (secondAt == 0 && n < 40) begin
      @(negedge clk);
      n++;
      if (writeReq) begin
        errorCount++;
        $display("%s: write strobe seen before the second fetch", testName);
      end
      if (readReq && firstAt == 0) begin
        firstAt = n;
        checkWord("first fetch address", 32'h0, ramAddress);
      end else if (readReq) begin
        secondAt   = n;
        secondAddr = ramAddress;
      end
    end
    if (secondAt == 0) begin
      errorCount++;
      $display("%s: second fetch never seen", testName);
    end
    checkWord("first fetch cycle", 2, firstAt);   // Request cycle, then strobe
    checkWord("fetch spacing", 5, secondAt - firstAt);
    checkWord("second fetch address", `PH_SHORT_INSTR_BYTES, secondAddr);
    awaitStall();
  endtask

  initial begin
    reset = 1'b0;
    ramIn = '0;
    #1 reset = 1'b1;   // Clean edge for the async reset
    arithmeticTest();
    loadStoreTest();
    stackTest();
    callTest();
    branchTest();
    timingTest();
    assertFails = phaethonCore_i.phaethonCore_props_i.failCount;
    $display("Checks: %0d, errors: %0d, assertion failures: %0d", checkCount, errorCount,
             assertFails);
    if (errorCount == 0 && assertFails == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

//--- verif/phaethonCore_props.sv
`timescale 1ns/1ps

module phaethonCore_props (
  input logic clk,
  input logic reset,
  input logic readReq,
  input logic writeReq
);

  int failCount = 0;   // Failed assertions so far

  // One RAM access at a time
  strobeExclusive: assert property (@(posedge clk) disable iff (reset) !(readReq && writeReq))
    else begin
      failCount++;
      $error("readReq and writeReq high in the same cycle");
    end

  // Strobes are single-cycle pulses
  readSingle: assert property (@(posedge clk) disable iff (reset) readReq |=> !readReq)
    else begin
      failCount++;
      $error("readReq held for more than one cycle");
    end
  writeSingle: assert property (@(posedge clk) disable iff (reset) writeReq |=> !writeReq)
    else begin
      failCount++;
      $error("writeReq held for more than one cycle");
    end

  // Async reset clears both
  quietInReset: assert property (@(posedge clk) reset |-> (!readReq && !writeReq))
    else begin
      failCount++;
      $error("RAM strobe active while reset is high");
    end

endmodule

bind phaethonCore phaethonCore_props phaethonCore_props_i (
  .clk, .reset, .readReq, .writeReq
);
